// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_mem_subsystem
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= TB PASSED

SOURCES := $(wildcard logic/*.sv logic/*.svh testbench/*.sv testbench/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

test: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== list.f ====
+incdir+logic
+incdir+testbench
logic/mem_pkg.sv
logic/mem_arbiter.sv
logic/mem_store.sv
logic/tx_queue.sv
logic/uart_tx.sv
logic/mem_subsystem.sv
testbench/tb_mem_subsystem.sv

// ==== logic/mem_arbiter.sv ====
`timescale 1ns/1ns

module mem_arbiter import mem_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,

    input  logic        inst_start,
    input  logic [31:0] i_addr,
    output logic        inst_ready,
    output logic [31:0] inst,
    output logic        inst_valid,

    input  logic        d_start,
    input  d_req_t      d_req,
    output logic        d_ready,
    output logic [31:0] rdata,
    output logic        rdata_valid,

    output logic        mem_start,
    output mem_cmd_t    mem_cmd,
    input  logic        mem_ready,
    input  logic [31:0] mem_rdata,
    input  logic        mem_rdata_valid
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT_READY,
        ST_WAIT_READ
    } state_t;

    state_t      state;
    logic        cmd_is_inst;   // command in flight belongs to the fetch port
    logic        d_pend;        // data request waits behind the fetch
    logic [31:0] save_i_addr;
    d_req_t      save_d;
    logic        rsp_valid;

    assign inst_ready = (state == ST_IDLE);
    assign d_ready    = (state == ST_IDLE);
    assign rsp_valid  = (state == ST_WAIT_READ) && mem_rdata_valid;

    always_comb begin
        mem_start = 1'b0;
        mem_cmd   = to_mem_cmd(save_d);
        case (state)
            ST_IDLE: begin
                mem_start = inst_start || d_start;
                mem_cmd   = inst_start ? fetch_cmd(i_addr) : to_mem_cmd(d_req);  // fetch wins
            end
            ST_WAIT_READY: begin
                mem_start = 1'b1;
                mem_cmd   = cmd_is_inst ? fetch_cmd(save_i_addr) : to_mem_cmd(save_d);
            end
            ST_WAIT_READ: begin
                // chain the saved data request on the fetch response
                mem_start = mem_rdata_valid && cmd_is_inst && d_pend;
            end
            default: begin
                mem_start = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= ST_IDLE;
            cmd_is_inst <= 1'b0;
            d_pend      <= 1'b0;
            inst_valid  <= 1'b0;
            rdata_valid <= 1'b0;
        end else begin
            inst_valid  <= rsp_valid && cmd_is_inst;
            rdata_valid <= rsp_valid && !cmd_is_inst;
            case (state)
                ST_IDLE: begin
                    if (inst_start) begin
                        cmd_is_inst <= 1'b1;
                        d_pend      <= d_start;
                        state       <= mem_ready ? ST_WAIT_READ : ST_WAIT_READY;
                    end else if (d_start) begin
                        cmd_is_inst <= 1'b0;
                        d_pend      <= 1'b0;
                        if (!mem_ready)
                            state <= ST_WAIT_READY;
                        else if (!d_req.write)  // a taken write keeps the FSM idle
                            state <= ST_WAIT_READ;
                    end
                end
                ST_WAIT_READY: begin
                    if (mem_ready) begin
                        if (cmd_is_inst || !save_d.write)
                            state <= ST_WAIT_READ;
                        else
                            state <= ST_IDLE;
                    end
                end
                ST_WAIT_READ: begin
                    if (mem_rdata_valid) begin
                        if (cmd_is_inst && d_pend) begin
                            cmd_is_inst <= 1'b0;
                            d_pend      <= 1'b0;
                            if (!mem_ready)
                                state <= ST_WAIT_READY;
                            else if (save_d.write)
                                state <= ST_IDLE;
                            else
                                state <= ST_WAIT_READ;
                        end else begin
                            state <= ST_IDLE;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE) begin
            save_i_addr <= i_addr;
            save_d      <= d_req;
        end
        if (rsp_valid && cmd_is_inst)
            inst <= mem_rdata;
        if (rsp_valid && !cmd_is_inst)
            rdata <= mem_rdata;
    end

    // read wait only follows a taken read, so the data is already there
    a_read_data_next: assert property (@(posedge clk) disable iff (!rst_n)
        (state == ST_WAIT_READ) |-> mem_rdata_valid);

endmodule

// ==== logic/mem_consts.svh ====
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// RAM depth in 32-bit words
`define MEM_WORDS 1024

// store here pushes the low byte to the serial port
`define UART_TX_ADDR 32'h0000_F000

// transmit FIFO depth in bytes
`define TXQ_DEPTH 8

// clocks per serial bit
`define BAUD_DIV 4

`endif

// ==== logic/mem_pkg.sv ====
package mem_pkg;

    // request as presented on the core data port
    typedef struct packed {
        logic        write;     // 1 = store, 0 = load
        logic [31:0] addr;      // byte address, word aligned
        logic [31:0] wdata;
        logic [3:0]  wmask;     // byte enables, bit 0 = lowest byte
    } d_req_t;

    // command on the single memory port
    typedef struct packed {
        logic        write;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wmask;
    } mem_cmd_t;

    function automatic mem_cmd_t to_mem_cmd(input d_req_t req);
        mem_cmd_t cmd;
        cmd.write = req.write;
        cmd.addr  = req.addr;
        cmd.wdata = req.wdata;
        cmd.wmask = req.wmask;
        return cmd;
    endfunction

    // instruction fetch is always a plain word read
    function automatic mem_cmd_t fetch_cmd(input logic [31:0] addr);
        mem_cmd_t cmd;
        cmd.write = 1'b0;
        cmd.addr  = addr;
        cmd.wdata = '0;
        cmd.wmask = '0;
        return cmd;
    endfunction

endpackage

// ==== logic/mem_store.sv ====
`timescale 1ns/1ns
`include "mem_consts.svh"

module mem_store import mem_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,

    input  logic        mem_start,
    input  mem_cmd_t    mem_cmd,
    output logic        mem_ready,
    output logic [31:0] mem_rdata,
    output logic        mem_rdata_valid,

    output logic        push,
    output logic [7:0]  push_data,
    input  logic        full
);

    localparam int AW = $clog2(`MEM_WORDS);

    logic [31:0]   ram [`MEM_WORDS];
    logic          take;
    logic          is_uart;
    logic [AW-1:0] word_idx;

    assign take     = mem_start && mem_ready;
    assign is_uart  = (mem_cmd.addr == `UART_TX_ADDR);
    assign word_idx = mem_cmd.addr[AW+1:2];     // byte address to word index

    // only stall source is a full transmit queue
    assign mem_ready = !full;

    assign push      = take && mem_cmd.write && is_uart && mem_cmd.wmask[0];
    assign push_data = mem_cmd.wdata[7:0];

    always_ff @(posedge clk) begin
        if (take && mem_cmd.write && !is_uart) begin
            for (int b = 0; b < 4; b++) begin
                if (mem_cmd.wmask[b])
                    ram[word_idx][8*b +: 8] <= mem_cmd.wdata[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take && !mem_cmd.write)
            mem_rdata <= is_uart ? 32'h0 : ram[word_idx];   // tx register reads as zero
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            mem_rdata_valid <= 1'b0;
        else
            mem_rdata_valid <= take && !mem_cmd.write;      // single cycle pulse
    end

    // a stalled command stays on the port unchanged
    a_hold_while_stalled: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_start && !mem_ready) |=> (mem_start && $stable(mem_cmd)));

endmodule

// ==== logic/mem_subsystem.sv ====
`timescale 1ns/1ns

module mem_subsystem import mem_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,

    input  logic        inst_start,
    input  logic [31:0] i_addr,
    output logic        inst_ready,
    output logic [31:0] inst,
    output logic        inst_valid,

    input  logic        d_start,
    input  d_req_t      d_req,
    output logic        d_ready,
    output logic [31:0] rdata,
    output logic        rdata_valid,

    output logic        txd
);

    logic        mem_start;
    mem_cmd_t    mem_cmd;
    logic        mem_ready;
    logic [31:0] mem_rdata;
    logic        mem_rdata_valid;

    logic        push;
    logic [7:0]  push_data;
    logic        full;
    logic [7:0]  pop_data;
    logic        not_empty;
    logic        pop;

    mem_arbiter i_arbiter (
        .clk, .rst_n,
        .inst_start, .i_addr, .inst_ready, .inst, .inst_valid,
        .d_start, .d_req, .d_ready, .rdata, .rdata_valid,
        .mem_start, .mem_cmd, .mem_ready, .mem_rdata, .mem_rdata_valid
    );

    mem_store i_store (
        .clk, .rst_n,
        .mem_start, .mem_cmd, .mem_ready, .mem_rdata, .mem_rdata_valid,
        .push, .push_data, .full
    );

    tx_queue i_queue (
        .clk, .rst_n,
        .push, .push_data, .full,
        .pop_data, .not_empty, .pop
    );

    uart_tx i_uart (
        .clk, .rst_n,
        .pop_data, .not_empty, .pop, .txd
    );

endmodule

// ==== logic/tx_queue.sv ====
`timescale 1ns/1ns
`include "mem_consts.svh"

module tx_queue (
    input  logic       clk,
    input  logic       rst_n,

    input  logic       push,
    input  logic [7:0] push_data,
    output logic       full,

    output logic [7:0] pop_data,
    output logic       not_empty,
    input  logic       pop
);

    localparam int AW = $clog2(`TXQ_DEPTH);
    localparam logic [AW-1:0] LAST  = AW'(`TXQ_DEPTH - 1);
    localparam logic [AW:0]   DEPTH = (AW+1)'(`TXQ_DEPTH);

    logic [7:0]    slots [`TXQ_DEPTH];
    logic [AW-1:0] head;        // next byte to send
    logic [AW-1:0] tail;        // next free slot
    logic [AW:0]   count;
    logic          do_push;
    logic          do_pop;

    assign full      = (count == DEPTH);
    assign not_empty = (count != '0);
    assign pop_data  = slots[head];

    assign do_push = push && !full;
    assign do_pop  = pop && not_empty;

    always_ff @(posedge clk) begin
        if (do_push)
            slots[tail] <= push_data;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (do_push)
                tail <= (tail == LAST) ? '0 : tail + 1'b1;
            if (do_pop)
                head <= (head == LAST) ? '0 : head + 1'b1;
            if (do_push && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !do_push)
                count <= count - 1'b1;
        end
    end

    a_no_pop_when_empty: assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> not_empty);

endmodule

// ==== logic/uart_tx.sv ====
`timescale 1ns/1ns
`include "mem_consts.svh"

module uart_tx (
    input  logic       clk,
    input  logic       rst_n,

    input  logic [7:0] pop_data,
    input  logic       not_empty,
    output logic       pop,
    output logic       txd
);

    localparam int BW = $clog2(`BAUD_DIV + 1);
    localparam logic [BW-1:0] BAUD_LAST = BW'(`BAUD_DIV - 1);

    logic          busy;
    logic [9:0]    shifter;     // stop, data lsb first, start
    logic [3:0]    bit_cnt;
    logic [BW-1:0] baud_cnt;

    assign pop = !busy && not_empty;
    assign txd = shifter[0];    // idles high, shifter refills with ones

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            shifter  <= '1;
            bit_cnt  <= '0;
            baud_cnt <= '0;
        end else if (pop) begin
            busy     <= 1'b1;
            shifter  <= {1'b1, pop_data, 1'b0};
            bit_cnt  <= '0;
            baud_cnt <= '0;
        end else if (busy) begin
            if (baud_cnt == BAUD_LAST) begin
                baud_cnt <= '0;
                shifter  <= {1'b1, shifter[9:1]};
                if (bit_cnt == 4'd9)
                    busy <= 1'b0;   // stop bit done
                else
                    bit_cnt <= bit_cnt + 1'b1;
            end else begin
                baud_cnt <= baud_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== testbench/tb_checks.svh ====
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// step to just after the next rising edge, inputs change and outputs are settled here
task automatic next_cycle();
    @(posedge clk);
    #1;
endtask

task automatic note_fail(input string msg);
    errors++;
    $display("%s", msg);
endtask

task automatic check_word(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp)
        note_fail($sformatf("CHECK FAILED %s %s: expected %h, actual %h",
                            test_name, what, exp, act));
endtask

task automatic check_byte(input string what, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp)
        note_fail($sformatf("CHECK FAILED %s %s: expected %h, actual %h",
                            test_name, what, exp, act));
endtask

task automatic check_cycles(input string what, input int exp, input int act);
    if (act != exp)
        note_fail($sformatf("CHECK FAILED %s %s cycles: expected %0d, actual %0d",
                            test_name, what, exp, act));
endtask

// hold start until the wanted ports are ready, then drop it after the taking edge
task automatic send_req(input logic do_inst, input logic [31:0] addr,
                        input logic do_data, input d_req_t req);
    int   n;
    logic go;
    n          = 0;
    i_addr     = addr;
    inst_start = do_inst;
    d_req      = req;
    d_start    = do_data;
    go         = (inst_ready || !do_inst) && (d_ready || !do_data);
    while (!go && n < WAIT_LIMIT) begin
        next_cycle();
        n++;
        stall_cycles++;
        go = (inst_ready || !do_inst) && (d_ready || !do_data);
    end
    if (go)
        next_cycle();   // request taken at this edge
    else
        note_fail($sformatf("%s: ready stayed low for %0d cycles", test_name, WAIT_LIMIT));
    inst_start = 1'b0;
    d_start    = 1'b0;
endtask

// latency counts edges after the accepting edge, zero means never seen
task automatic wait_response(input logic want_i, input logic want_d,
                             output logic [31:0] i_word, output int i_lat,
                             output logic [31:0] d_word, output int d_lat);
    int n;
    n      = 0;
    i_lat  = 0;
    d_lat  = 0;
    i_word = 'x;
    d_word = 'x;
    while (((want_i && i_lat == 0) || (want_d && d_lat == 0)) && n < WAIT_LIMIT) begin
        next_cycle();
        n++;
        if (inst_valid && !want_i)
            note_fail($sformatf("%s: inst_valid pulsed with no fetch pending", test_name));
        if (rdata_valid && !want_d)
            note_fail($sformatf("%s: rdata_valid pulsed with no read pending", test_name));
        if (inst_valid && i_lat == 0) begin
            i_lat  = n;
            i_word = inst;
        end
        if (rdata_valid && d_lat == 0) begin
            d_lat  = n;
            d_word = rdata;
        end
    end
    if ((want_i && i_lat == 0) || (want_d && d_lat == 0))
        note_fail($sformatf("%s: no response within %0d cycles", test_name, WAIT_LIMIT));
endtask

// 8N1 receiver, samples each bit in its middle
task automatic decode_frame(output logic [7:0] data, output logic ok);
    int n;
    n    = 0;
    data = '0;
    while (txd !== 1'b0 && n < FRAME_WAIT) begin
        next_cycle();
        n++;
    end
    ok = (txd === 1'b0);
    if (!ok) begin
        note_fail($sformatf("%s: no start bit on txd within %0d cycles", test_name, FRAME_WAIT));
    end else begin
        repeat (`BAUD_DIV / 2) next_cycle();
        if (txd !== 1'b0) begin
            ok = 1'b0;
            note_fail($sformatf("%s: start bit on txd ended early", test_name));
        end
        for (int i = 0; i < 8; i++) begin
            repeat (`BAUD_DIV) next_cycle();
            data[i] = txd;  // lsb first
        end
        repeat (`BAUD_DIV) next_cycle();
        if (txd !== 1'b1) begin
            ok = 1'b0;
            note_fail($sformatf("%s: stop bit on txd was low", test_name));
        end
    end
endtask

`endif

// ==== testbench/tb_mem_subsystem.sv ====
`timescale 1ns/1ns
`include "mem_consts.svh"

module tb_mem_subsystem import mem_pkg::*; ();

    localparam int WAIT_LIMIT = 200;                    // cycles per handshake or response
    localparam int FRAME_WAIT = 4 * 10 * `BAUD_DIV;     // cycles to wait for a start bit
    localparam int BURST      = `TXQ_DEPTH + 4;

    logic        clk;
    logic        rst_n;
    logic        inst_start;
    logic [31:0] i_addr;
    logic        inst_ready;
    logic [31:0] inst;
    logic        inst_valid;
    logic        d_start;
    d_req_t      d_req;
    logic        d_ready;
    logic [31:0] rdata;
    logic        rdata_valid;
    logic        txd;

    logic [31:0] model [`MEM_WORDS];    // expected RAM contents
    string       test_name;
    int          errors;
    int          err_at_start;
    int          tests_run;
    int          tests_failed;
    int          stall_cycles;

    mem_subsystem i_dut (
        .clk, .rst_n,
        .inst_start, .i_addr, .inst_ready, .inst, .inst_valid,
        .d_start, .d_req, .d_ready, .rdata, .rdata_valid,
        .txd
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    `include "tb_checks.svh"

    function automatic int word_of(input logic [31:0] addr);
        return int'(addr >> 2) % `MEM_WORDS;
    endfunction

    function automatic logic [31:0] random_addr();
        return ($urandom % `MEM_WORDS) << 2;
    endfunction

    function automatic d_req_t make_req(input logic write, input logic [31:0] addr,
                                        input logic [31:0] wdata, input logic [3:0] wmask);
        d_req_t r;
        r.write = write;
        r.addr  = addr;
        r.wdata = wdata;
        r.wmask = wmask;
        return r;
    endfunction

    task automatic data_write(input logic [31:0] addr, input logic [31:0] wdata,
                              input logic [3:0] wmask);
        send_req(1'b0, '0, 1'b1, make_req(1'b1, addr, wdata, wmask));
        for (int b = 0; b < 4; b++) begin
            if (wmask[b])
                model[word_of(addr)][8*b +: 8] = wdata[8*b +: 8];  // byte strobe merge
        end
    endtask

    task automatic read_and_check(input logic [31:0] addr);
        logic [31:0] iw;
        logic [31:0] dw;
        int          il;
        int          dl;
        send_req(1'b0, '0, 1'b1, make_req(1'b0, addr, '0, '0));
        wait_response(1'b0, 1'b1, iw, il, dw, dl);
        check_word($sformatf("rdata @%h", addr), model[word_of(addr)], dw);
        check_cycles("rdata_valid", 1, dl);
    endtask

    task automatic begin_test(input string name);
        test_name    = name;
        err_at_start = errors;
        tests_run++;
    endtask

    task automatic end_test();
        if (errors == err_at_start) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d check(s) failed", test_name, errors - err_at_start);
        end
    endtask

    task automatic test_reset_state();
        begin_test("reset_state");
        for (int i = 0; i < 20; i++) begin
            if (!inst_ready || !d_ready)
                note_fail($sformatf("%s: a ready signal was low at cycle %0d", test_name, i));
            if (inst_valid || rdata_valid)
                note_fail($sformatf("%s: a valid pulse appeared at cycle %0d", test_name, i));
            if (txd !== 1'b1)
                note_fail($sformatf("%s: txd left idle at cycle %0d", test_name, i));
            next_cycle();
        end
        end_test();
    endtask

    task automatic test_write_read();
        logic [31:0] addr [8];
        begin_test("write_read");
        for (int i = 0; i < 8; i++) begin
            addr[i] = random_addr();
            data_write(addr[i], $urandom, 4'hf);    // known contents first
        end
        for (int i = 0; i < 8; i++) begin
            data_write(addr[i], $urandom, 4'($urandom));
            read_and_check(addr[i]);
        end
        end_test();
    endtask

    task automatic test_fetch();
        logic [31:0] addr [4];
        logic [31:0] iw;
        logic [31:0] dw;
        int          il;
        int          dl;
        begin_test("fetch");
        for (int i = 0; i < 4; i++) begin
            addr[i] = random_addr();
            data_write(addr[i], $urandom, 4'hf);
        end
        for (int i = 0; i < 4; i++) begin
            send_req(1'b1, addr[i], 1'b0, '0);
            wait_response(1'b1, 1'b0, iw, il, dw, dl);
            check_word($sformatf("inst @%h", addr[i]), model[word_of(addr[i])], iw);
            check_cycles("inst_valid", 1, il);
        end
        end_test();
    endtask

    task automatic test_fetch_and_read();
        logic [31:0] ia;
        logic [31:0] da;
        logic [31:0] iw;
        logic [31:0] dw;
        int          il;
        int          dl;
        begin_test("fetch_and_read");
        for (int i = 0; i < 4; i++) begin
            ia = random_addr();
            da = random_addr();
            data_write(ia, $urandom, 4'hf);
            data_write(da, $urandom, 4'hf);
            send_req(1'b1, ia, 1'b1, make_req(1'b0, da, '0, '0));
            wait_response(1'b1, 1'b1, iw, il, dw, dl);
            check_word($sformatf("inst @%h", ia), model[word_of(ia)], iw);
            check_word($sformatf("rdata @%h", da), model[word_of(da)], dw);
            check_cycles("inst_valid", 1, il);
            check_cycles("rdata_valid", 2, dl);     // data waits behind the fetch
        end
        end_test();
    endtask

    // stores and the line decoder run side by side
    task automatic stream_bytes(input int count);
        logic [7:0] data [$];
        logic [7:0] got;
        logic       ok;
        ok = 1'b1;
        for (int i = 0; i < count; i++)
            data.push_back(8'($urandom));
        fork
            begin
                for (int i = 0; i < count; i++)
                    send_req(1'b0, '0, 1'b1,
                             make_req(1'b1, `UART_TX_ADDR, {24'h0, data[i]}, 4'b0001));
            end
            begin
                for (int i = 0; i < count && ok; i++) begin
                    decode_frame(got, ok);
                    if (ok)
                        check_byte($sformatf("serial byte %0d", i), data[i], got);
                end
            end
        join
    endtask

    task automatic test_uart();
        begin_test("uart");
        stream_bytes(5);
        read_and_check_zero();
        end_test();
    endtask

    task automatic read_and_check_zero();
        logic [31:0] iw;
        logic [31:0] dw;
        int          il;
        int          dl;
        send_req(1'b0, '0, 1'b1, make_req(1'b0, `UART_TX_ADDR, '0, '0));
        wait_response(1'b0, 1'b1, iw, il, dw, dl);
        check_word("rdata of tx register", 32'h0, dw);
    endtask

    task automatic test_back_pressure();
        begin_test("back_pressure");
        stall_cycles = 0;
        stream_bytes(BURST);
        if (stall_cycles == 0)
            note_fail($sformatf("%s: d_ready never dropped with the queue full", test_name));
        end_test();
    endtask

    initial begin
        void'($urandom(32'h7534140d));
        rst_n        = 1'b0;
        inst_start   = 1'b0;
        i_addr       = '0;
        d_start      = 1'b0;
        d_req        = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        stall_cycles = 0;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;

        test_reset_state();
        test_write_read();
        test_fetch();
        test_fetch_and_read();
        test_uart();
        test_back_pressure();

        $display("tests run %0d, tests failed %0d, checks failed %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule
